//--- tb.f
src/frame_pkg.sv
src/edge_trigger_detect.sv
src/trigger_arm_fsm.sv
src/sample_capture.sv
src/frame_writer.sv
src/sample_frame_top.sv
testbench/sample_frame_props.sv
testbench/sample_frame_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module sample_frame_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vsample_frame_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0

//--- testbench/sample_frame_tb.sv
`timescale 1ns/10ps

module sample_frame_tb
    import frame_pkg::*;
;

    // One scenario row
    typedef struct packed {
        logic       en;
        logic [1:0] src;
        logic [1:0] typ;
        logic [1:0] pin;
        logic       fall;
        logic       use_tgt;
        logic       flag;
    } row_t;

    localparam int NUM_ROWS   = 10;
    localparam int TGT_OFFSET = 6;
    // Edges from the ID 31 beat until ts_irq is seen high
    localparam int IRQ_DELAY  = FRAME_WORDS + 3;

    // en, source, edge type, pin (0 none, 1 ext, 2 mcu), falling, target, expected flag
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, SRC_PINS, EDGE_RISE, 2'd1, 1'b0, 1'b0, 1'b1},
        '{1'b1, SRC_PINS, EDGE_FALL, 2'd2, 1'b1, 1'b0, 1'b1},
        '{1'b1, SRC_PINS, EDGE_BOTH, 2'd1, 1'b1, 1'b0, 1'b1},
        '{1'b1, SRC_PINS, EDGE_RISE, 2'd1, 1'b1, 1'b0, 1'b0},
        '{1'b1, SRC_PINS, 2'd3,      2'd2, 1'b0, 1'b0, 1'b0},
        '{1'b1, SRC_RTC,  EDGE_RISE, 2'd0, 1'b0, 1'b1, 1'b1},
        '{1'b0, SRC_RTC,  EDGE_RISE, 2'd0, 1'b0, 1'b1, 1'b0},
        '{1'b1, SRC_PINS, EDGE_RISE, 2'd0, 1'b0, 1'b1, 1'b0},
        '{1'b1, SRC_PINS, EDGE_BOTH, 2'd2, 1'b0, 1'b0, 1'b1},
        '{1'b1, SRC_PINS, EDGE_FALL, 2'd1, 1'b0, 1'b0, 1'b0}
    };

    logic        aclk;
    logic        aresetn;
    logic [31:0] fast_tdata;
    logic        fast_tvalid;
    logic        fast_tready;
    logic [31:0] slow_tdata;
    logic        slow_tvalid;
    logic        slow_tready;
    logic        ext_trigger_in;
    logic        mcu_trigger_in;
    logic [31:0] rtc_second;
    logic [31:0] rtc_nanosecond;
    logic        trigger_enable;
    logic [1:0]  trigger_source;
    logic [1:0]  trigger_type;
    logic [31:0] target_second;
    logic [31:0] target_nanosecond;
    logic [11:0] bram_addr;
    logic        bram_en;
    logic [1:0]  bram_we;
    logic [15:0] bram_din;
    logic        ts_irq;

    int          errors;
    int          writes;
    int          next_addr;
    logic [15:0] mem [64];
    logic [15:0] exp_mem [FRAME_WORDS];
    logic [15:0] fast_val [32];
    logic [23:0] slow_val [NUM_SLOW_CH];
    logic [31:0] exp_trg_ns;

    sample_frame_top dut (.*);

    always #4 aclk = ~aclk;

    // Free-running clock source with one nanosecond step per cycle
    always @(posedge aclk) begin
        rtc_nanosecond <= rtc_nanosecond + 32'd1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // BRAM model that records every full write
    always @(posedge aclk) begin
        if (aresetn && bram_en && bram_we == 2'b11) begin
            check_value("write address", 32'(bram_addr), 32'(next_addr));
            mem[bram_addr[5:0]] = bram_din;
            next_addr++;
            writes++;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    task automatic set_pin(input logic [1:0] which, input logic level);
        if (which == 2'd1) begin
            ext_trigger_in <= level;
        end else if (which == 2'd2) begin
            mcu_trigger_in <= level;
        end
    endtask

    // Sends IDs 0 to 30 shuffled and 31 last, returns the clock value seen with ID 0
    task automatic send_frame(output logic [31:0] stamp_ns);
        int order [31];
        int j;
        int tmp;
        for (int i = 0; i < 31; i++) begin
            order[i] = i;
        end
        for (int i = 30; i > 0; i--) begin
            j = int'($urandom % 32'(i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 32; i++) begin
            fast_val[i] = 16'($urandom);
        end
        for (int i = 0; i < NUM_SLOW_CH; i++) begin
            slow_val[i] = 24'($urandom);
        end
        stamp_ns = '0;
        for (int i = 0; i < 32; i++) begin
            @(posedge aclk);
            check_value("fast_tready", 32'(fast_tready), 32'd1);
            check_value("slow_tready", 32'(slow_tready), 32'd1);
            j = (i < 31) ? order[i] : 31;
            // DUT samples the clock value after this edge
            if (j == 0) begin
                stamp_ns = rtc_nanosecond + 32'd1;
            end
            fast_tdata  <= {8'd0, 8'(j), fast_val[j]};
            fast_tvalid <= 1'b1;
            if (i < NUM_SLOW_CH) begin
                slow_tdata  <= {8'(i), slow_val[i]};
                slow_tvalid <= 1'b1;
            end else begin
                slow_tvalid <= 1'b0;
            end
        end
        @(posedge aclk);
        fast_tvalid <= 1'b0;
    endtask

    // Frame image from the layout and channel map
    task automatic build_expected(input logic [31:0] stamp_ns, input logic flag);
        int id;
        exp_mem[ADDR_STAMP]     = rtc_second[31:16];
        exp_mem[ADDR_STAMP + 1] = rtc_second[15:0];
        exp_mem[ADDR_STAMP + 2] = stamp_ns[31:16];
        exp_mem[ADDR_STAMP + 3] = stamp_ns[15:0];
        for (int i = 0; i < NUM_FAST_CH; i++) begin
            id = (i < 8) ? 4 * i + 3 : 4 * (i - 8) + 1;
            exp_mem[ADDR_PCH + i] = fast_val[id];
            id = (i < 8) ? 4 * i + 2 : 4 * (i - 8);
            exp_mem[ADDR_TCH + i] = fast_val[id];
        end
        for (int i = 0; i < NUM_SLOW_CH; i++) begin
            exp_mem[ADDR_PT + 2 * i]     = {8'd0, slow_val[i][23:16]};
            exp_mem[ADDR_PT + 2 * i + 1] = slow_val[i][15:0];
        end
        // Trigger time is latched one cycle after the stamp
        if (flag) begin
            exp_trg_ns = stamp_ns + 32'd1;
        end
        exp_mem[ADDR_TRG_FLAG]     = {15'd0, flag};
        exp_mem[ADDR_TRG_TIME]     = rtc_second[31:16];
        exp_mem[ADDR_TRG_TIME + 1] = rtc_second[15:0];
        exp_mem[ADDR_TRG_TIME + 2] = exp_trg_ns[31:16];
        exp_mem[ADDR_TRG_TIME + 3] = exp_trg_ns[15:0];
    endtask

    task automatic wait_irq(input logic level, input int limit, output bit ok,
                            output int cycles);
        ok     = 1'b0;
        cycles = 0;
        for (int n = 0; n < limit; n++) begin
            @(posedge aclk);
            cycles = n + 1;
            if (ts_irq === level) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        logic [31:0] stamp_ns;
        bit          ok;
        int          cycles;
        row_t        r;
        aclk              = 1'b0;
        aresetn           = 1'b0;
        fast_tdata        = '0;
        fast_tvalid       = 1'b0;
        slow_tdata        = '0;
        slow_tvalid       = 1'b0;
        ext_trigger_in    = 1'b0;
        mcu_trigger_in    = 1'b0;
        rtc_second        = 32'h0001_2c00;
        rtc_nanosecond    = 32'd1000;
        trigger_enable    = 1'b0;
        trigger_source    = SRC_PINS;
        trigger_type      = EDGE_RISE;
        target_second     = 32'h0001_2c00;
        target_nanosecond = 32'hffff_ffff;
        errors            = 0;
        writes            = 0;
        next_addr         = 0;
        exp_trg_ns        = '0;
        void'($urandom(17050));
        repeat (10) @(posedge aclk);
        // Outputs held low in reset
        check_value("fast_tready in reset", 32'(fast_tready), 32'd0);
        check_value("slow_tready in reset", 32'(slow_tready), 32'd0);
        check_value("bram_en in reset", 32'(bram_en), 32'd0);
        check_value("bram_we in reset", 32'(bram_we), 32'd0);
        check_value("ts_irq in reset", 32'(ts_irq), 32'd0);
        aresetn <= 1'b1;
        repeat (3) @(posedge aclk);

        for (int row = 0; row < NUM_ROWS; row++) begin
            r = ROWS[row];
            // Disarm and settle the pin at its start level
            @(posedge aclk);
            trigger_enable <= 1'b0;
            set_pin(r.pin, r.fall);
            repeat (6) @(posedge aclk);
            trigger_source    <= r.src;
            trigger_type      <= r.typ;
            trigger_enable    <= r.en;
            target_nanosecond <= r.use_tgt ? rtc_nanosecond + 32'(TGT_OFFSET) : 32'hffff_ffff;
            repeat (3) @(posedge aclk);
            set_pin(r.pin, ~r.fall);
            repeat (12) @(posedge aclk);

            for (int a = 0; a < 64; a++) begin
                mem[a] = 16'ha500 ^ 16'(a * 37);
            end
            writes    = 0;
            next_addr = 0;
            send_frame(stamp_ns);
            build_expected(stamp_ns, r.flag);
            wait_irq(1'b1, 100, ok, cycles);
            if (!ok) begin
                errors++;
                $display("Timeout: the interrupt did not rise after frame %0d", row);
                break;
            end
            check_value("interrupt delay", 32'(cycles), 32'(IRQ_DELAY));
            check_value("write count", 32'(writes), 32'(FRAME_WORDS));
            for (int a = 0; a < FRAME_WORDS; a++) begin
                check_value($sformatf("row %0d word %0d", row, a), 32'(mem[a]),
                            32'(exp_mem[a]));
            end
            wait_irq(1'b0, IRQ_PULSE_CYCLES + 20, ok, cycles);
            if (!ok) begin
                errors++;
                $display("Timeout: the interrupt did not fall after frame %0d", row);
                break;
            end
            check_value("interrupt width", 32'(cycles), 32'(IRQ_PULSE_CYCLES));
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- testbench/sample_frame_props.sv
`timescale 1ns/10ps

module sample_frame_props
    import frame_pkg::*;
(
    input logic        aclk,
    input logic        aresetn,
    input logic        fast_tready,
    input logic        slow_tready,
    input logic [11:0] bram_addr,
    input logic        bram_en,
    input logic [1:0]  bram_we,
    input logic        ts_irq
);

    // Every BRAM access is a full halfword write
    assert property (@(posedge aclk) disable iff (!aresetn)
        bram_en |-> bram_we == 2'b11)
        else $error("BRAM enable without full write strobe");

    // Addresses step by one, a restart goes back to 0
    assert property (@(posedge aclk) disable iff (!aresetn)
        (bram_en && $past(bram_en) && bram_addr != 12'd0) |->
            bram_addr == $past(bram_addr) + 12'd1)
        else $error("BRAM address did not advance by one");

    assert property (@(posedge aclk) disable iff (!aresetn)
        $past(aresetn) |-> (fast_tready && slow_tready))
        else $error("tready dropped after reset");

    assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(ts_irq) |-> ##(IRQ_PULSE_CYCLES - 1) ts_irq ##1 !ts_irq)
        else $error("Interrupt width is wrong");

endmodule

bind sample_frame_top sample_frame_props props (.*);

//--- src/sample_frame_top.sv
`timescale 1ns/10ps

module sample_frame_top
    import frame_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    // Fast converter stream
    input  logic [31:0] fast_tdata,
    input  logic        fast_tvalid,
    output logic        fast_tready,
    // Slow thermometer stream
    input  logic [31:0] slow_tdata,
    input  logic        slow_tvalid,
    output logic        slow_tready,
    input  logic        ext_trigger_in,
    input  logic        mcu_trigger_in,
    input  logic [31:0] rtc_second,
    input  logic [31:0] rtc_nanosecond,
    // Host trigger control
    input  logic        trigger_enable,
    input  logic [1:0]  trigger_source,
    input  logic [1:0]  trigger_type,
    input  logic [31:0] target_second,
    input  logic [31:0] target_nanosecond,
    // BRAM write port
    output logic [11:0] bram_addr,
    output logic        bram_en,
    output logic [1:0]  bram_we,
    output logic [15:0] bram_din,
    output logic        ts_irq
);

    logic                      stamp_beat;
    logic                      frame_last;
    logic [31:0]               stamp_second;
    logic [31:0]               stamp_nanosecond;
    logic [NUM_FAST_CH*16-1:0] pch_flat;
    logic [NUM_FAST_CH*16-1:0] tch_flat;
    logic [NUM_SLOW_CH*24-1:0] pt_flat;
    logic                      ext_pulse;
    logic                      mcu_pulse;
    logic                      trg_flag;
    logic [31:0]               trg_second;
    logic [31:0]               trg_nanosecond;

    sample_capture capture (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .fast_tdata       (fast_tdata),
        .fast_tvalid      (fast_tvalid),
        .fast_tready      (fast_tready),
        .slow_tdata       (slow_tdata),
        .slow_tvalid      (slow_tvalid),
        .slow_tready      (slow_tready),
        .rtc_second       (rtc_second),
        .rtc_nanosecond   (rtc_nanosecond),
        .stamp_beat       (stamp_beat),
        .frame_last       (frame_last),
        .stamp_second     (stamp_second),
        .stamp_nanosecond (stamp_nanosecond),
        .pch_flat         (pch_flat),
        .tch_flat         (tch_flat),
        .pt_flat          (pt_flat)
    );

    // ------------------------------
    // Trigger path
    // ------------------------------

    edge_trigger_detect ext_edge (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .pin        (ext_trigger_in),
        .edge_type  (trigger_type),
        .edge_pulse (ext_pulse)
    );

    edge_trigger_detect mcu_edge (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .pin        (mcu_trigger_in),
        .edge_type  (trigger_type),
        .edge_pulse (mcu_pulse)
    );

    trigger_arm_fsm arm (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .trigger_enable    (trigger_enable),
        .trigger_source    (trigger_source),
        .ext_pulse         (ext_pulse),
        .mcu_pulse         (mcu_pulse),
        .rtc_second        (rtc_second),
        .rtc_nanosecond    (rtc_nanosecond),
        .target_second     (target_second),
        .target_nanosecond (target_nanosecond),
        .stamp_beat        (stamp_beat),
        .trg_flag          (trg_flag),
        .trg_second        (trg_second),
        .trg_nanosecond    (trg_nanosecond)
    );

    frame_writer writer (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .frame_last       (frame_last),
        .stamp_second     (stamp_second),
        .stamp_nanosecond (stamp_nanosecond),
        .pch_flat         (pch_flat),
        .tch_flat         (tch_flat),
        .pt_flat          (pt_flat),
        .trg_flag         (trg_flag),
        .trg_second       (trg_second),
        .trg_nanosecond   (trg_nanosecond),
        .bram_addr        (bram_addr),
        .bram_en          (bram_en),
        .bram_we          (bram_we),
        .bram_din         (bram_din),
        .ts_irq           (ts_irq)
    );

endmodule

//--- src/frame_writer.sv
`timescale 1ns/10ps

module frame_writer
    import frame_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      frame_last,
    input  logic [31:0]               stamp_second,
    input  logic [31:0]               stamp_nanosecond,
    input  logic [NUM_FAST_CH*16-1:0] pch_flat,
    input  logic [NUM_FAST_CH*16-1:0] tch_flat,
    input  logic [NUM_SLOW_CH*24-1:0] pt_flat,
    input  logic                      trg_flag,
    input  logic [31:0]               trg_second,
    input  logic [31:0]               trg_nanosecond,
    output logic [11:0]               bram_addr,
    output logic                      bram_en,
    output logic [1:0]                bram_we,
    output logic [15:0]               bram_din,
    output logic                      ts_irq
);

    logic [WORD_CNT_W-1:0] wr_cnt;
    logic                  wr_busy;
    logic                  wr_done;
    logic [63:0]           stamp_words;
    logic [63:0]           trg_words;
    logic [15:0]           din_next;
    logic [IRQ_CNT_W-1:0]  irq_cnt;

    // ------------------------------
    // Word sequencer
    // ------------------------------

    assign wr_done = wr_busy && (wr_cnt == WORD_CNT_W'(FRAME_WORDS - 1));

    // A new frame_last restarts from word 0
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_busy <= 1'b0;
            wr_cnt  <= '0;
        end else if (frame_last) begin
            wr_busy <= 1'b1;
            wr_cnt  <= '0;
        end else if (wr_done) begin
            wr_busy <= 1'b0;
        end else if (wr_busy) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Seconds first, high half first
    assign stamp_words = {stamp_second, stamp_nanosecond};
    assign trg_words   = {trg_second, trg_nanosecond};

    always_comb begin : din_select
        int k;
        int ch;
        k  = int'(wr_cnt);
        ch = (k - ADDR_PT) / 2;
        if (k < ADDR_PCH) begin
            din_next = stamp_words[63 - 16*(k - ADDR_STAMP) -: 16];
        end else if (k < ADDR_TCH) begin
            din_next = pch_flat[16*(k - ADDR_PCH) +: 16];
        end else if (k < ADDR_PT) begin
            din_next = tch_flat[16*(k - ADDR_TCH) +: 16];
        end else if (k < ADDR_TRG_FLAG) begin
            // Thermometer as zero-extended high byte then low half
            if (((k - ADDR_PT) % 2) == 0) begin
                din_next = {8'd0, pt_flat[24*ch + 16 +: 8]};
            end else begin
                din_next = pt_flat[24*ch +: 16];
            end
        end else if (k == ADDR_TRG_FLAG) begin
            din_next = {15'd0, trg_flag};
        end else if (k < FRAME_WORDS) begin
            din_next = trg_words[63 - 16*(k - ADDR_TRG_TIME) -: 16];
        end else begin
            din_next = '0;
        end
    end

    // ------------------------------
    // BRAM port
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bram_en   <= 1'b0;
            bram_we   <= 2'b00;
            bram_addr <= '0;
        end else begin
            bram_en   <= wr_busy;
            bram_we   <= wr_busy ? 2'b11 : 2'b00;
            bram_addr <= wr_busy ? 12'(wr_cnt) : 12'd0;
        end
    end

    always_ff @(posedge aclk) begin
        bram_din <= din_next;
    end

    // Interrupt stretch, counts 1 to IRQ_PULSE_CYCLES
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            irq_cnt <= '0;
        end else if (wr_done) begin
            irq_cnt <= IRQ_CNT_W'(1);
        end else if (irq_cnt == IRQ_CNT_W'(IRQ_PULSE_CYCLES)) begin
            irq_cnt <= '0;
        end else if (irq_cnt != '0) begin
            irq_cnt <= irq_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ts_irq <= 1'b0;
        end else begin
            ts_irq <= (irq_cnt != '0);
        end
    end

endmodule

//--- src/sample_capture.sv
`timescale 1ns/10ps

module sample_capture
    import frame_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [31:0]               fast_tdata,
    input  logic                      fast_tvalid,
    output logic                      fast_tready,
    input  logic [31:0]               slow_tdata,
    input  logic                      slow_tvalid,
    output logic                      slow_tready,
    input  logic [31:0]               rtc_second,
    input  logic [31:0]               rtc_nanosecond,
    output logic                      stamp_beat,
    output logic                      frame_last,
    output logic [31:0]               stamp_second,
    output logic [31:0]               stamp_nanosecond,
    output logic [NUM_FAST_CH*16-1:0] pch_flat,
    output logic [NUM_FAST_CH*16-1:0] tch_flat,
    output logic [NUM_SLOW_CH*24-1:0] pt_flat
);

    logic       fast_beat;
    logic       slow_beat;
    logic [7:0] fast_id;
    logic [7:0] slow_id;

    // Mux IDs as routed on the board
    // IDs 4k+3 and 4k+2 feed slots 0 to 7, IDs 4k+1 and 4k feed slots 8 to 15
    function automatic logic [7:0] pch_id(input int slot);
        if (slot < NUM_FAST_CH / 2) begin
            return 8'(4 * slot + 3);
        end
        return 8'(4 * (slot - NUM_FAST_CH / 2) + 1);
    endfunction

    function automatic logic [7:0] tch_id(input int slot);
        if (slot < NUM_FAST_CH / 2) begin
            return 8'(4 * slot + 2);
        end
        return 8'(4 * (slot - NUM_FAST_CH / 2));
    endfunction

    assign fast_beat = fast_tvalid && fast_tready;
    assign slow_beat = slow_tvalid && slow_tready;
    assign fast_id   = fast_tdata[23:16];
    assign slow_id   = slow_tdata[31:24];

    // Always ready once out of reset
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fast_tready <= 1'b0;
            slow_tready <= 1'b0;
        end else begin
            fast_tready <= 1'b1;
            slow_tready <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stamp_beat <= 1'b0;
            frame_last <= 1'b0;
        end else begin
            stamp_beat <= fast_beat && (fast_id == 8'd0);
            frame_last <= fast_beat && (fast_id == 8'(LAST_FAST_ID));
        end
    end

    // Channel 0 opens a frame
    always_ff @(posedge aclk) begin
        if (fast_beat && fast_id == 8'd0) begin
            stamp_second     <= rtc_second;
            stamp_nanosecond <= rtc_nanosecond;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_FAST_CH; i++) begin
            if (fast_beat && fast_id == pch_id(i)) begin
                pch_flat[16*i +: 16] <= fast_tdata[15:0];
            end
            if (fast_beat && fast_id == tch_id(i)) begin
                tch_flat[16*i +: 16] <= fast_tdata[15:0];
            end
        end
    end

    // Slow IDs map straight to slots
    always_ff @(posedge aclk) begin
        for (int j = 0; j < NUM_SLOW_CH; j++) begin
            if (slow_beat && slow_id == 8'(j)) begin
                pt_flat[24*j +: 24] <= slow_tdata[23:0];
            end
        end
    end

endmodule

//--- src/trigger_arm_fsm.sv
`timescale 1ns/10ps

module trigger_arm_fsm
    import frame_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        trigger_enable,
    input  logic [1:0]  trigger_source,
    input  logic        ext_pulse,
    input  logic        mcu_pulse,
    input  logic [31:0] rtc_second,
    input  logic [31:0] rtc_nanosecond,
    input  logic [31:0] target_second,
    input  logic [31:0] target_nanosecond,
    input  logic        stamp_beat,
    output logic        trg_flag,
    output logic [31:0] trg_second,
    output logic [31:0] trg_nanosecond
);

    enum logic [1:0] {ST_RESET, ST_IDLE, ST_ARMED, ST_TRIGGERED} state, state_next;

    logic rtc_match;
    logic fire;

    // ------------------------------
    // Trigger source select
    // ------------------------------

    assign rtc_match = (rtc_second == target_second) &&
                       (rtc_nanosecond == target_nanosecond);

    always_comb begin
        case (trigger_source)
            SRC_PINS: fire = ext_pulse | mcu_pulse;
            SRC_RTC:  fire = rtc_match;
            default:  fire = 1'b0;
        endcase
    end

    // ------------------------------
    // Arm state machine
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_RESET:     state_next = ST_IDLE;
            ST_IDLE:      state_next = trigger_enable ? ST_ARMED : ST_IDLE;
            ST_ARMED: begin
                if (!trigger_enable) begin
                    state_next = ST_IDLE;
                end else if (fire) begin
                    state_next = ST_TRIGGERED;
                end
            end
            // Held until the next frame stamp picks it up
            ST_TRIGGERED: begin
                if (!trigger_enable || stamp_beat) begin
                    state_next = ST_IDLE;
                end
            end
            default:      state_next = ST_RESET;
        endcase
    end

    // Flag and trigger time, sampled once per frame
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            trg_flag <= 1'b0;
        end else if (stamp_beat) begin
            trg_flag <= (state == ST_TRIGGERED);
        end
    end

    always_ff @(posedge aclk) begin
        if (stamp_beat && state == ST_TRIGGERED) begin
            trg_second     <= rtc_second;
            trg_nanosecond <= rtc_nanosecond;
        end
    end

endmodule

//--- src/edge_trigger_detect.sv
`timescale 1ns/10ps

module edge_trigger_detect
    import frame_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       pin,
    input  logic [1:0] edge_type,
    output logic       edge_pulse
);

    logic pin_meta;
    logic pin_sync;
    logic pin_prev;
    logic rise;
    logic fall;
    logic hit;

    // Two-flop synchronizer plus history
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pin_meta <= 1'b0;
            pin_sync <= 1'b0;
            pin_prev <= 1'b0;
        end else begin
            pin_meta <= pin;
            pin_sync <= pin_meta;
            pin_prev <= pin_sync;
        end
    end

    assign rise = pin_sync & ~pin_prev;
    assign fall = ~pin_sync & pin_prev;

    always_comb begin
        case (edge_type)
            EDGE_RISE: hit = rise;
            EDGE_FALL: hit = fall;
            EDGE_BOTH: hit = rise | fall;
            // Reserved code
            default:   hit = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            edge_pulse <= 1'b0;
        end else begin
            edge_pulse <= hit;
        end
    end

endmodule

//--- src/frame_pkg.sv
package frame_pkg;

    // ------------------------------
    // Channel counts
    // ------------------------------

    // Pressure and temperature channels each
    localparam int NUM_FAST_CH  = 16;
    // Thermometer channels on the slow stream
    localparam int NUM_SLOW_CH  = 3;
    // Fast channel that closes a frame
    localparam int LAST_FAST_ID = 31;

    // ------------------------------
    // Frame layout in halfwords
    // ------------------------------

    localparam int FRAME_WORDS   = 47;
    localparam int ADDR_STAMP    = 0;
    localparam int ADDR_PCH      = 4;
    localparam int ADDR_TCH      = 20;
    localparam int ADDR_PT       = 36;
    localparam int ADDR_TRG_FLAG = 42;
    localparam int ADDR_TRG_TIME = 43;
    localparam int WORD_CNT_W    = $clog2(FRAME_WORDS);

    // Interrupt width in aclk cycles
    localparam int IRQ_PULSE_CYCLES = 511;
    localparam int IRQ_CNT_W        = $clog2(IRQ_PULSE_CYCLES + 1);

    // ------------------------------
    // Trigger encodings
    // ------------------------------

    localparam logic [1:0] SRC_PINS  = 2'd0;
    localparam logic [1:0] SRC_RTC   = 2'd3;
    localparam logic [1:0] EDGE_RISE = 2'd0;
    localparam logic [1:0] EDGE_FALL = 2'd1;
    localparam logic [1:0] EDGE_BOTH = 2'd2;

endpackage
